//--- sim.f
rtl/mrnw_pkg.sv
rtl/bank_rd_if.sv
rtl/sram_1r1w.sv
rtl/live_value_table.sv
rtl/mrnw_init.sv
rtl/mrnw_read_select.sv
rtl/mrnw_mem_top.sv
test/clk_gen.sv
test/mrnw_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f sim.f --top-module mrnw_tb --Mdir "$BUILD_DIR" -o mrnw_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/mrnw_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

//--- test/mrnw_tb.sv
module mrnw_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mrnw_pkg::*;

  localparam int WIDTH   = DEF_WIDTH;
  localparam int NUMADDR = DEF_NUMADDR;
  localparam int BITADDR = $clog2(DEF_NUMADDR);
  localparam int NUMWRPT = DEF_NUMWRPT;
  localparam int NUMRDPT = DEF_NUMRDPT;

  logic                       clk;
  logic                       rst_n;
  logic                       rst_req;
  logic [NUMWRPT-1:0]         write;
  logic [NUMWRPT*BITADDR-1:0] wr_adr;
  logic [NUMWRPT*WIDTH-1:0]   din;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic                       ready;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;

  logic [WIDTH-1:0]   shadow [NUMADDR];     // reference copy of the memory.
  logic [WIDTH-1:0]   exp_q [NUMRDPT][$];   // expected words per read port.
  int                 issue_q [NUMRDPT][$]; // cycle of each outstanding read.
  logic [WIDTH-1:0]   exp_head [NUMRDPT];
  int                 exp_issue [NUMRDPT];
  logic [NUMRDPT-1:0] exp_empty = '1;
  int                 cyc = 0;
  int                 since_rst = 0;
  init_state_t        init_st;

  integer seed = 32'h89f2_ff13;
  int     err_cnt = 0;
  int     to_cnt = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  clk_gen u_clk (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  mrnw_mem_top UUT (.*);

  assign init_st = UUT.u_init.state;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  always @(posedge clk) begin
    cyc++;
    if (!rst_n) begin
      since_rst = 0;
      for (int j = 0; j < NUMRDPT; j++) begin
        exp_q[j].delete();
        issue_q[j].delete();
      end
    end else begin
      if (since_rst < NUMADDR) since_rst++;
      for (int j = 0; j < NUMRDPT; j++) begin
        if (rd_vld[j] && exp_q[j].size() > 0) begin  // checked at the last falling edge.
          void'(exp_q[j].pop_front());
          void'(issue_q[j].pop_front());
        end
      end
      if (ready === 1'b1) begin
        // reads take the words from before this cycle's writes.
        for (int j = 0; j < NUMRDPT; j++) begin
          if (read[j]) begin
            exp_q[j].push_back(shadow[rd_adr[j*BITADDR +: BITADDR]]);
            issue_q[j].push_back(cyc - 1);  // the request was driven before this edge.
          end
        end
        for (int i = 0; i < NUMWRPT; i++) begin  // upward, so the top port wins.
          if (write[i]) shadow[wr_adr[i*BITADDR +: BITADDR]] = din[i*WIDTH +: WIDTH];
        end
      end
    end
    if (ready !== 1'b1) begin
      for (int a = 0; a < NUMADDR; a++) shadow[a] = '0;  // what the clear sweep leaves.
    end
    for (int j = 0; j < NUMRDPT; j++) begin
      exp_empty[j] = (exp_q[j].size() == 0);
      exp_head[j]  = exp_empty[j] ? '0 : exp_q[j][0];
      exp_issue[j] = exp_empty[j] ? 0 : issue_q[j][0];
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  for (genvar j = 0; j < NUMRDPT; j++) begin : g_chk
    a_data : assert property (@(negedge clk) disable iff (!rst_n)
      (rd_vld[j] && !exp_empty[j]) |-> rd_dout[j*WIDTH +: WIDTH] == exp_head[j])
    else begin
      $display("FAILED %0t rd_dout[%0d] got %h expected %h",
               $time, j, rd_dout[j*WIDTH +: WIDTH], exp_head[j]);
      err_cnt++;
    end

    a_latency : assert property (@(negedge clk) disable iff (!rst_n)
      (rd_vld[j] && !exp_empty[j]) |-> cyc == exp_issue[j] + READ_LATENCY)
    else begin
      $display("FAILED %0t rd_vld[%0d] latency got %0d expected %0d",
               $time, j, cyc - exp_issue[j], READ_LATENCY);
      err_cnt++;
    end

    a_missing : assert property (@(negedge clk) disable iff (!rst_n)
      (!exp_empty[j] && cyc >= exp_issue[j] + READ_LATENCY) |-> rd_vld[j])
    else begin
      $display("read port %0d gave no data for its read of cycle %0d", j, exp_issue[j]);
      err_cnt++;
    end

    a_spurious : assert property (@(negedge clk) disable iff (!rst_n)
      rd_vld[j] |-> !exp_empty[j])
    else begin
      $display("read port %0d returned data that no read asked for", j);
      err_cnt++;
    end
  end

  a_ready_time : assert property (@(negedge clk) disable iff (!rst_n)
    ready == (since_rst >= NUMADDR))
  else begin
    $display("FAILED %0t ready got %b expected %b", $time, ready, since_rst >= NUMADDR);
    err_cnt++;
  end

  a_init_state : assert property (@(negedge clk)
    init_st == ((since_rst >= NUMADDR) ? DONE : CLEAR))
  else begin
    $display("FAILED %0t u_init.state got %0d expected %0d",
             $time, init_st, (since_rst >= NUMADDR) ? DONE : CLEAR);
    err_cnt++;
  end

  a_quiet : assert property (@(negedge clk) disable iff (!rst_n)
    !ready |-> rd_vld == '0)
  else begin
    $display("FAILED %0t rd_vld got %b expected %b while ready is low",
             $time, rd_vld, {NUMRDPT{1'b0}});
    err_cnt++;
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  function automatic int rand_below(int range);
    return ($random(seed) & 32'h7fff_ffff) % range;
  endfunction

  task automatic clear_requests();
    write = '0;
    read  = '0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    clear_requests();
  endtask

  task automatic put_write(int port, int adr, logic [WIDTH-1:0] data);
    write[port] = 1'b1;
    wr_adr[port*BITADDR +: BITADDR] = BITADDR'(adr);
    din[port*WIDTH +: WIDTH] = data;
  endtask

  task automatic put_read(int port, int adr);
    read[port] = 1'b1;
    rd_adr[port*BITADDR +: BITADDR] = BITADDR'(adr);
  endtask

  task automatic drive_random(int adr_range);
    for (int i = 0; i < NUMWRPT; i++) begin
      if (rand_below(4) != 0) put_write(i, rand_below(adr_range), WIDTH'($random(seed)));
    end
    for (int j = 0; j < NUMRDPT; j++) begin
      if (rand_below(4) != 0) put_read(j, rand_below(adr_range));
    end
  endtask

  task automatic await_ready(logic level, int limit, bit noisy);
    int n;
    n = 0;
    while (ready !== level && n < limit) begin
      next_cycle();
      if (noisy) drive_random(NUMADDR);
      n++;
    end
    clear_requests();
    if (ready !== level) begin
      $display("timeout: ready did not become %0b within %0d cycles", level, limit);
      to_cnt++;
    end
  endtask

  task automatic drain_reads(int limit);
    int n;
    n = 0;
    next_cycle();
    while ((exp_empty != '1 || rd_vld != '0) && n < limit) begin
      next_cycle();
      n++;
    end
    if (exp_empty != '1 || rd_vld != '0) begin
      $display("timeout: reads still outstanding after %0d cycles", limit);
      to_cnt++;
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < NUMADDR; a++) begin
      next_cycle();
      for (int j = 0; j < NUMRDPT; j++) put_read(j, (a + j * 7) % NUMADDR);
    end
    drain_reads(20);
  endtask

  task automatic end_test(string name, int fails_before);
    int fails;
    fails = err_cnt + to_cnt - fails_before;
    tests_run++;
    if (fails == 0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, fails);
    end
  endtask

  initial begin
    int base;
    rst_req = 1'b0;
    write   = '0;
    wr_adr  = '0;
    din     = '0;
    read    = '0;
    rd_adr  = '0;

    base = err_cnt + to_cnt;  // requests during the sweep must be dropped.
    await_ready(1'b1, NUMADDR + 20, 1'b1);
    read_all();
    end_test("reset", base);

    base = err_cnt + to_cnt;
    for (int k = 0; k < 16; k++) begin
      next_cycle();
      for (int i = 0; i < NUMWRPT; i++) put_write(i, k + i * 32, WIDTH'($random(seed)));
    end
    for (int k = 0; k < 32; k++) begin
      next_cycle();
      for (int j = 0; j < NUMRDPT; j++) put_read(j, ((k + j * 16) % 16) + ((k / 16) * 32));
    end
    drain_reads(20);
    end_test("distinct", base);

    base = err_cnt + to_cnt;
    for (int k = 0; k < 4; k++) begin
      next_cycle();
      for (int i = 0; i < NUMWRPT; i++) put_write(i, 40 + k, WIDTH'($random(seed)));
    end
    for (int k = 0; k < 4; k++) begin
      next_cycle();
      for (int j = 0; j < NUMRDPT; j++) put_read(j, 40 + k);
    end
    drain_reads(20);
    end_test("collision", base);

    base = err_cnt + to_cnt;
    for (int i = 0; i < NUMWRPT; i++) begin
      next_cycle();
      put_write(i, 8, WIDTH'($random(seed)));
      for (int j = 0; j < NUMRDPT; j++) put_read(j, 8);
      next_cycle();
      for (int j = 0; j < NUMRDPT; j++) put_read(j, 8);
    end
    drain_reads(20);
    end_test("same_cycle", base);

    base = err_cnt + to_cnt;
    for (int c = 0; c < 300; c++) begin
      next_cycle();
      drive_random(NUMADDR / 4);  // a narrow range makes collisions likely.
    end
    drain_reads(20);
    end_test("random", base);

    base = err_cnt + to_cnt;
    for (int a = 0; a < NUMADDR; a++) begin
      next_cycle();
      put_write(0, a, WIDTH'(a + 1));
    end
    next_cycle();
    rst_req <= 1'b1;
    next_cycle();
    rst_req <= 1'b0;
    await_ready(1'b0, 10, 1'b0);
    await_ready(1'b1, NUMADDR + 20, 1'b1);
    read_all();
    end_test("second_reset", base);

    $display("tests %0d, failed %0d, check errors %0d, timeouts %0d",
             tests_run, tests_failed, err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- test/clk_gen.sv
module clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 8
) (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  int rst_cnt = RST_CYCLES;

  initial clk = 1'b0;

  always #(PERIOD_NS / 2.0) clk = ~clk;

  // reset holds for RST_CYCLES rising edges and starts over on rst_req.
  always @(negedge clk) begin
    if (rst_req) begin
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt > 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst_n = (rst_cnt == 0);

endmodule

//--- rtl/mrnw_mem_top.sv
module mrnw_mem_top #(
  parameter int WIDTH   = mrnw_pkg::DEF_WIDTH,
  parameter int NUMADDR = mrnw_pkg::DEF_NUMADDR,
  parameter int BITADDR = $clog2(NUMADDR),
  parameter int NUMWRPT = mrnw_pkg::DEF_NUMWRPT,
  parameter int NUMRDPT = mrnw_pkg::DEF_NUMRDPT
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic                       ready,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout
);

  import mrnw_pkg::*;

  localparam int BITWRPT = (NUMWRPT > 1) ? $clog2(NUMWRPT) : 1;

  typedef logic [WIDTH-1:0] payload_t;

  logic                       init_write;
  logic [BITADDR-1:0]         init_adr;
  logic [NUMWRPT-1:0]         bk_write;
  logic [NUMWRPT*BITADDR-1:0] bk_wr_adr;
  logic [NUMWRPT*WIDTH-1:0]   bk_din;
  logic [NUMWRPT-1:0]         lvt_write;
  logic [NUMRDPT-1:0]         read_g;
  logic [NUMRDPT*BITWRPT-1:0] lvt_sel;

  // ------------------------------------------------------------
  // init sweep and port gating
  // ------------------------------------------------------------

  mrnw_init #(.NUMADDR(NUMADDR), .BITADDR(BITADDR)) u_init (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (ready),
    .init_write (init_write),
    .init_adr   (init_adr)
  );

  // while clearing, every bank takes zeros and only port 0 marks the LVT.
  assign bk_write  = ready ? write  : {NUMWRPT{init_write}};
  assign bk_wr_adr = ready ? wr_adr : {NUMWRPT{init_adr}};
  assign bk_din    = ready ? din    : '0;
  assign lvt_write = ready ? write  : NUMWRPT'(init_write);
  assign read_g    = ready ? read   : '0;  // reads before ready are dropped.

  live_value_table #(
    .NUMADDR(NUMADDR), .BITADDR(BITADDR), .NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT)
  ) u_lvt (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (lvt_write),
    .wr_adr (bk_wr_adr),
    .read   (read_g),
    .rd_adr (rd_adr),
    .rd_sel (lvt_sel)
  );

  // ------------------------------------------------------------
  // one bank per write port and read port
  // ------------------------------------------------------------

  for (genvar j = 0; j < NUMRDPT; j++) begin : g_rd
    bank_rd_if #(.BITADDR(BITADDR), .payload_t(payload_t)) bif [NUMWRPT] ();

    for (genvar i = 0; i < NUMWRPT; i++) begin : g_wr
      assign bif[i].read   = read_g[j];
      assign bif[i].rd_adr = rd_adr[j*BITADDR +: BITADDR];

      sram_1r1w #(.payload_t(payload_t), .NUMADDR(NUMADDR), .BITADDR(BITADDR)) u_bank (
        .clk    (clk),
        .write  (bk_write[i]),
        .wr_adr (bk_wr_adr[i*BITADDR +: BITADDR]),
        .din    (bk_din[i*WIDTH +: WIDTH]),
        .rd     (bif[i])
      );
    end

    mrnw_read_select #(.WIDTH(WIDTH), .NUMWRPT(NUMWRPT)) u_sel (
      .clk     (clk),
      .rst_n   (rst_n),
      .banks   (bif),
      .sel     (lvt_sel[j*BITWRPT +: BITWRPT]),
      .rd_vld  (rd_vld[j]),
      .rd_dout (rd_dout[j*WIDTH +: WIDTH])
    );

    // the bank, LVT and select stages add up to the fixed latency.
    a_rd_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      read_g[j] |-> ##READ_LATENCY rd_vld[j]
    ) else $error("mrnw_mem_top: read port %0d missed its latency", j);
  end

endmodule

//--- rtl/mrnw_read_select.sv
module mrnw_read_select #(
  parameter int WIDTH   = mrnw_pkg::DEF_WIDTH,
  parameter int NUMWRPT = mrnw_pkg::DEF_NUMWRPT
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  bank_rd_if.reader                                       banks [NUMWRPT],
  input  logic [((NUMWRPT > 1) ? $clog2(NUMWRPT) : 1)-1:0] sel,
  output logic                                            rd_vld,
  output logic [WIDTH-1:0]                                rd_dout
);

  logic [WIDTH-1:0]   data_w [NUMWRPT];
  logic [NUMWRPT-1:0] vld_w;

  // interface arrays only take constant indices, so tap them here.
  for (genvar i = 0; i < NUMWRPT; i++) begin : g_bank_tap
    assign data_w[i] = banks[i].rd_dout;
    assign vld_w[i]  = banks[i].rd_vld;
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= vld_w[0];  // every bank of this port sees the same read.
    end
  end

  always_ff @(posedge clk) begin
    if (vld_w[0]) begin
      rd_dout <= data_w[sel];  // the live copy, as named by the LVT.
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // the banks of one read port share read, so they must return together.
  a_vld_agree : assert property (
    @(posedge clk) disable iff (!rst_n)
    vld_w == {NUMWRPT{vld_w[0]}}
  ) else $error("mrnw_read_select: bank rd_vld mismatch %b", vld_w);

endmodule

//--- rtl/mrnw_init.sv
module mrnw_init #(
  parameter int NUMADDR = mrnw_pkg::DEF_NUMADDR,
  parameter int BITADDR = $clog2(NUMADDR)
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic               ready,
  output logic               init_write,
  output logic [BITADDR-1:0] init_adr
);

  import mrnw_pkg::*;

  localparam logic [BITADDR-1:0] LAST_ADR = BITADDR'(NUMADDR - 1);

  init_state_t state;

  // one address per cycle, NUMADDR cycles in all.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= CLEAR;
      init_adr <= '0;
    end else begin
      case (state)
        CLEAR: begin
          if (init_adr == LAST_ADR) begin
            state <= DONE;
          end else begin
            init_adr <= init_adr + 1'b1;
          end
        end
        default: begin
          state <= DONE;  // holds here until the next reset.
        end
      endcase
    end
  end

  assign init_write = (state == CLEAR);
  assign ready      = (state == DONE);

endmodule

//--- rtl/live_value_table.sv
module live_value_table #(
  parameter int NUMADDR = mrnw_pkg::DEF_NUMADDR,
  parameter int BITADDR = $clog2(NUMADDR),
  parameter int NUMWRPT = mrnw_pkg::DEF_NUMWRPT,
  parameter int NUMRDPT = mrnw_pkg::DEF_NUMRDPT
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [NUMWRPT-1:0]                                  write,
  input  logic [NUMWRPT*BITADDR-1:0]                          wr_adr,
  input  logic [NUMRDPT-1:0]                                  read,
  input  logic [NUMRDPT*BITADDR-1:0]                          rd_adr,
  output logic [NUMRDPT*((NUMWRPT > 1) ? $clog2(NUMWRPT) : 1)-1:0] rd_sel
);

  localparam int BITWRPT = (NUMWRPT > 1) ? $clog2(NUMWRPT) : 1;

  // one entry per address naming the write port that wrote it last.
  logic [BITWRPT-1:0] lvt_mem [NUMADDR];

  // ------------------------------------------------------------
  // update
  // ------------------------------------------------------------

  // ports are scanned upward, so on a collision the last nonblocking
  // assignment, from the highest active port, is the one that sticks.
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUMWRPT; i++) begin
      if (write[i]) begin
        lvt_mem[wr_adr[i*BITADDR +: BITADDR]] <= BITWRPT'(i);
      end
    end
  end

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------

  // registered to line up with the bank output one cycle later.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_sel <= '0;
    end else begin
      for (int j = 0; j < NUMRDPT; j++) begin
        if (read[j]) begin
          rd_sel[j*BITWRPT +: BITWRPT] <= lvt_mem[rd_adr[j*BITADDR +: BITADDR]];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  for (genvar j = 0; j < NUMRDPT; j++) begin : g_sel_chk
    a_sel_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_sel[j*BITWRPT +: BITWRPT] < NUMWRPT
    ) else $error("live_value_table: read port %0d names a missing write port", j);
  end

endmodule

//--- rtl/sram_1r1w.sv
module sram_1r1w #(
  parameter type payload_t = logic [mrnw_pkg::DEF_WIDTH-1:0],
  parameter int  NUMADDR   = mrnw_pkg::DEF_NUMADDR,
  parameter int  BITADDR   = $clog2(NUMADDR)
) (
  input  logic               clk,
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  payload_t           din,
  bank_rd_if.bank            rd
);

  payload_t mem [NUMADDR];

  // ------------------------------------------------------------
  // write port
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= din;
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------

  // the read samples the array before this edge's write lands, so a
  // read and a write to one address return the old word.
  always_ff @(posedge clk) begin
    if (rd.read) begin
      rd.rd_dout <= mem[rd.rd_adr];
    end
  end

  always_ff @(posedge clk) begin
    rd.rd_vld <= rd.read;  // data is valid one cycle after the request.
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  a_rd_adr_range : assert property (
    @(posedge clk) rd.read |-> (rd.rd_adr < NUMADDR)
  ) else $error("sram_1r1w: read address %0d out of range", rd.rd_adr);

  a_wr_adr_range : assert property (
    @(posedge clk) write |-> (wr_adr < NUMADDR)
  ) else $error("sram_1r1w: write address %0d out of range", wr_adr);

endmodule

//--- rtl/bank_rd_if.sv
interface bank_rd_if #(
  parameter int  BITADDR   = $clog2(mrnw_pkg::DEF_NUMADDR),
  parameter type payload_t = logic [mrnw_pkg::DEF_WIDTH-1:0]
);

  logic               read;     // read enable from the reader.
  logic [BITADDR-1:0] rd_adr;   // read address from the reader.
  logic               rd_vld;   // read delayed by one cycle.
  payload_t           rd_dout;  // word read from the bank.

  // the side that issues the read and takes the data.
  modport reader (
    output read,
    output rd_adr,
    input  rd_vld,
    input  rd_dout
  );

  // the bank itself.
  modport bank (
    input  read,
    input  rd_adr,
    output rd_vld,
    output rd_dout
  );

endinterface

//--- rtl/mrnw_pkg.sv
package mrnw_pkg;

  // ------------------------------------------------------------
  // timing
  // ------------------------------------------------------------

  // one cycle of bank access plus the output register.
  localparam int READ_LATENCY = 2;

  // ------------------------------------------------------------
  // default sizes for the top level
  // ------------------------------------------------------------

  localparam int DEF_WIDTH   = 16;  // data bits per word.
  localparam int DEF_NUMADDR = 64;  // words in the memory.
  localparam int DEF_NUMWRPT = 2;   // write ports.
  localparam int DEF_NUMRDPT = 2;   // read ports.

  // ------------------------------------------------------------
  // init sweep
  // ------------------------------------------------------------

  // the sweep writes zeros through CLEAR and then stays in DONE
  // until the next reset.
  typedef enum logic {
    CLEAR = 1'b0,
    DONE  = 1'b1
  } init_state_t;

endpackage
